/* Makefile */
SIM_LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f vlog.f --top-module trace_top

sim:
	verilator --binary --timing --assert -f vlog.f --top-module tb_trace_top
	./obj_dir/Vtb_trace_top > $(SIM_LOG) 2>&1 || true
	cat $(SIM_LOG)
	grep -q "TB PASSED" $(SIM_LOG)

clean:
	rm -rf obj_dir $(SIM_LOG)

/* design/retire_if.sv */
`timescale 1ns/1ps

interface retire_if;

  import trace_pkg::*;

  logic       push;  // One-cycle strobe, no handshake
  trace_rec_t rec;   // Valid only while push is high
  logic       full;  // Queue cannot take another record

  // Tracker side, never waits on full
  modport tracker (
    output push,
    output rec,
    input  full
  );

  // Queue side, drops the record when full
  modport queue (
    input  push,
    input  rec,
    output full
  );

endinterface

/* design/retire_queue.sv */
`timescale 1ns/1ps

module retire_queue #(
  parameter int depth = trace_pkg::queue_depth_default
) (
  input  logic                  clk,
  input  logic                  rst_n,
  retire_if.queue               ret,
  input  logic                  pop,
  output trace_pkg::trace_rec_t head,
  output logic                  not_empty,
  output logic [7:0]            drop_count
);

  import trace_pkg::*;

  localparam int aw = (depth > 1) ? $clog2(depth) : 1;  // Pointer width
  localparam int cw = $clog2(depth + 1);               // Count reaches depth

  trace_rec_t      mem [depth];   // Storage, oldest at rd_ptr
  logic [aw-1:0]   wr_ptr;
  logic [aw-1:0]   rd_ptr;
  logic [cw-1:0]   count;         // Occupancy
  logic            do_push;
  logic            do_pop;

  // Wrap at depth, works for non power of two
  function automatic logic [aw-1:0] ptr_next(input logic [aw-1:0] p);
    return (p == aw'(depth - 1)) ? '0 : p + 1'b1;
  endfunction

  assign ret.full  = (count == cw'(depth));
  assign not_empty = (count != '0);
  assign head      = mem[rd_ptr];           // Oldest record
  assign do_push   = ret.push && !ret.full;  // Full push is dropped
  assign do_pop    = pop && not_empty;

  //////////////////////////////////////////////////
  // Pointers, occupancy, drop counter
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      drop_count <= '0;
    end else begin
      if (do_push) wr_ptr <= ptr_next(wr_ptr);
      if (do_pop)  rd_ptr <= ptr_next(rd_ptr);
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;             // Both or neither
      endcase
      // Saturates at 255
      if (ret.push && ret.full && (drop_count != 8'hff)) begin
        drop_count <= drop_count + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= ret.rec;
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // Sender only completes a handshake on a queued record
  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (!rst_n)
    pop |-> not_empty
  );

  a_count_bound: assert property (
    @(posedge clk) disable iff (!rst_n)
    count <= cw'(depth)
  );

endmodule

/* design/retire_sender.sv */
`timescale 1ns/1ps

module retire_sender (
  input  logic                  clk,
  input  logic                  rst_n,
  input  trace_pkg::trace_rec_t head,
  input  logic                  not_empty,
  output logic                  pop,
  output logic                  out_req,
  input  logic                  out_ack,
  output trace_pkg::trace_rec_t out_rec
);

  // Four-phase master states
  typedef enum logic [1:0] {
    snd_idle    = 2'd0,  // Waiting for a queued record
    snd_req     = 2'd1,  // req high until ack rises
    snd_release = 2'd2   // req low until ack drops
  } snd_state_e;

  snd_state_e state;

  //////////////////////////////////////////////////
  // Handshake FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= snd_idle;
    end else begin
      case (state)
        snd_idle: begin
          if (not_empty) state <= snd_req;     // Raise req next cycle
        end
        snd_req: begin
          if (out_ack) state <= snd_release;   // Logger took it
        end
        snd_release: begin
          if (!out_ack) state <= snd_idle;     // Pop as the cycle completes
        end
        default: state <= snd_idle;
      endcase
    end
  end

  // Fields frozen from req rise until ack falls
  always_ff @(posedge clk) begin
    if (state == snd_idle && not_empty) out_rec <= head;
  end

  assign out_req = (state == snd_req);
  assign pop     = (state == snd_release) && !out_ack;  // One cycle strobe

endmodule

/* design/stage_tracker.sv */
`timescale 1ns/1ps

module stage_tracker (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         fetch_valid,
  input  logic                         stall,
  input  logic [31:0]                  fetch_pc,
  input  trace_pkg::op_t               op,
  input  logic [trace_pkg::note_w-1:0] fetch_note,
  input  logic [trace_pkg::note_w-1:0] decode_note,
  input  logic [trace_pkg::note_w-1:0] exec_note,
  input  logic [trace_pkg::note_w-1:0] mem_note,
  input  logic [trace_pkg::note_w-1:0] wb_note,
  retire_if.tracker                    ret
);

  import trace_pkg::*;

  // One slot index per CPU stage
  typedef enum logic [2:0] {
    pos_fetch     = 3'd0,
    pos_decode    = 3'd1,
    pos_execute   = 3'd2,
    pos_memory    = 3'd3,
    pos_writeback = 3'd4
  } stage_e;

  logic [4:0] vld;        // Slot occupied
  trace_rec_t recs [5];   // Record per slot
  trace_rec_t fresh;      // New record at fetch
  trace_rec_t from_f;     // Records as they leave each slot
  trace_rec_t from_d;
  trace_rec_t from_e;
  trace_rec_t from_m;
  trace_rec_t from_w;
  logic       push_q;     // Retire strobe
  trace_rec_t rec_q;      // Retired record with wb note

  // Stall count saturates instead of wrapping
  function automatic logic [stall_cnt_w-1:0] sat_inc(input logic [stall_cnt_w-1:0] c);
    return (&c) ? c : c + 1'b1;
  endfunction

  //////////////////////////////////////////////////
  // Note capture on the leaving edge
  //////////////////////////////////////////////////

  always_comb begin
    fresh              = '0;
    fresh.pc           = fetch_pc;      // Only pc known at fetch
    fresh.op           = op_nop;

    from_f             = recs[pos_fetch];
    from_f.fetch_note  = fetch_note;

    from_d             = recs[pos_decode];
    from_d.decode_note = decode_note;
    from_d.op          = op;            // Class is known once decoded

    from_e             = recs[pos_execute];
    from_e.exec_note   = exec_note;

    from_m             = recs[pos_memory];
    from_m.mem_note    = mem_note;

    from_w             = recs[pos_writeback];
    from_w.wb_note     = wb_note;       // Last note completes the record
  end

  //////////////////////////////////////////////////
  // Slot occupancy and retire strobe
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld    <= '0;
      push_q <= 1'b0;
    end else begin
      if (!stall) begin
        vld[pos_fetch]   <= fetch_valid;        // Fetch accepted
        vld[pos_decode]  <= vld[pos_fetch];
        vld[pos_execute] <= vld[pos_decode];
      end else begin
        vld[pos_execute] <= 1'b0;               // Front end holds and execute takes a bubble
      end
      // Back end always moves
      vld[pos_memory]    <= vld[pos_execute];
      vld[pos_writeback] <= vld[pos_memory];
      push_q             <= vld[pos_writeback]; // Bubbles never retire
    end
  end

  //////////////////////////////////////////////////
  // Record payload
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!stall) begin
      recs[pos_fetch]   <= fresh;
      recs[pos_decode]  <= from_f;
      recs[pos_execute] <= from_d;
    end else begin
      // Held records count the stall edge
      if (vld[pos_fetch]) begin
        recs[pos_fetch].stall_cycles  <= sat_inc(recs[pos_fetch].stall_cycles);
      end
      if (vld[pos_decode]) begin
        recs[pos_decode].stall_cycles <= sat_inc(recs[pos_decode].stall_cycles);
      end
    end
    recs[pos_memory]    <= from_e;
    recs[pos_writeback] <= from_m;
    rec_q               <= from_w;   // Meaningful only with push_q
  end

  assign ret.push = push_q;
  assign ret.rec  = rec_q;

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // Front-end slots only ever add stall edges while holding
  for (genvar g = 0; g < 2; g++) begin : g_hold_chk
    a_stall_no_dec: assert property (
      @(posedge clk) disable iff (!rst_n)
      (stall && vld[g]) |=>
        (recs[g].stall_cycles >= $past(recs[g].stall_cycles))
    );
  end

endmodule

/* design/trace_pkg.sv */
package trace_pkg;

  //////////////////////////////////////////////////
  // Sizes shared by tracker, queue and sender
  //////////////////////////////////////////////////

  localparam int note_w              = 8;  // One stage note tag
  localparam int queue_depth_default = 4;  // Retire queue entries
  localparam int stall_cnt_w         = 3;  // Stall counter, saturates at 7

  //////////////////////////////////////////////////
  // Decoded instruction class
  //////////////////////////////////////////////////

  typedef enum logic [2:0] {
    op_nop    = 3'd0,  // Also the value before decode
    op_alu    = 3'd1,
    op_load   = 3'd2,
    op_store  = 3'd3,
    op_branch = 3'd4,
    op_jump   = 3'd5
  } op_t;

  //////////////////////////////////////////////////
  // One completed trace record
  //////////////////////////////////////////////////

  // Field order is also the bit order, pc in the MSBs
  typedef struct packed {
    logic [31:0]            pc;            // Fetch address
    op_t                    op;            // Captured when leaving decode
    logic [note_w-1:0]      fetch_note;
    logic [note_w-1:0]      decode_note;
    logic [note_w-1:0]      exec_note;
    logic [note_w-1:0]      mem_note;
    logic [note_w-1:0]      wb_note;
    logic [stall_cnt_w-1:0] stall_cycles;  // Fetch plus decode stall edges
  } trace_rec_t;

  // Record width, handy for debug dumps
  localparam int trace_rec_w = $bits(trace_rec_t);

endpackage

/* design/trace_top.sv */
`timescale 1ns/1ps

module trace_top #(
  parameter int queue_depth = trace_pkg::queue_depth_default
) (
  input  logic                              clk,
  input  logic                              rst_n,
  // CPU side
  input  logic                              fetch_valid,
  input  logic [31:0]                       fetch_pc,
  input  logic                              stall,
  input  trace_pkg::op_t                    op,
  input  logic [trace_pkg::note_w-1:0]      fetch_note,
  input  logic [trace_pkg::note_w-1:0]      decode_note,
  input  logic [trace_pkg::note_w-1:0]      exec_note,
  input  logic [trace_pkg::note_w-1:0]      mem_note,
  input  logic [trace_pkg::note_w-1:0]      wb_note,
  // Logger side
  output logic                              out_req,
  output logic [31:0]                       out_pc,
  output trace_pkg::op_t                    out_op,
  output logic [trace_pkg::note_w-1:0]      out_fetch_note,
  output logic [trace_pkg::note_w-1:0]      out_decode_note,
  output logic [trace_pkg::note_w-1:0]      out_exec_note,
  output logic [trace_pkg::note_w-1:0]      out_mem_note,
  output logic [trace_pkg::note_w-1:0]      out_wb_note,
  output logic [trace_pkg::stall_cnt_w-1:0] out_stall_cycles,
  input  logic                              out_ack,
  // Status
  output logic [7:0]                        drop_count
);

  import trace_pkg::*;

  retire_if   ret_bus ();  // Tracker to queue
  trace_rec_t head;        // Queue head to sender
  trace_rec_t out_rec;     // Record held during handshake
  logic       not_empty;
  logic       pop;

  stage_tracker u_tracker (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch_valid (fetch_valid),
    .stall       (stall),
    .fetch_pc    (fetch_pc),
    .op          (op),
    .fetch_note  (fetch_note),
    .decode_note (decode_note),
    .exec_note   (exec_note),
    .mem_note    (mem_note),
    .wb_note     (wb_note),
    .ret         (ret_bus.tracker)
  );

  retire_queue #(.depth(queue_depth)) u_queue (
    .clk        (clk),
    .rst_n      (rst_n),
    .ret        (ret_bus.queue),
    .pop        (pop),
    .head       (head),
    .not_empty  (not_empty),
    .drop_count (drop_count)
  );

  retire_sender u_sender (
    .clk       (clk),
    .rst_n     (rst_n),
    .head      (head),
    .not_empty (not_empty),
    .pop       (pop),
    .out_req   (out_req),
    .out_ack   (out_ack),
    .out_rec   (out_rec)
  );

  // Flatten record for the logger
  assign out_pc           = out_rec.pc;
  assign out_op           = out_rec.op;
  assign out_fetch_note   = out_rec.fetch_note;
  assign out_decode_note  = out_rec.decode_note;
  assign out_exec_note    = out_rec.exec_note;
  assign out_mem_note     = out_rec.mem_note;
  assign out_wb_note      = out_rec.wb_note;
  assign out_stall_cycles = out_rec.stall_cycles;

endmodule

/* tb/tb_trace_table.svh */
`ifndef TB_TRACE_TABLE_SVH
`define TB_TRACE_TABLE_SVH

// Columns are phase, pc, op, fetch/decode/exec/mem/wb notes, fetch stalls, decode stalls
// Phase 1 plain, 2 stalls, 3 random ack delays, 4 burst with ack held low
typedef struct packed {
  logic [2:0]        phase;
  logic [31:0]       pc;
  op_t               op;
  logic [note_w-1:0] f_note;
  logic [note_w-1:0] d_note;
  logic [note_w-1:0] e_note;
  logic [note_w-1:0] m_note;
  logic [note_w-1:0] w_note;
  logic [3:0]        f_stall;   // Stall edges requested while in fetch
  logic [3:0]        d_stall;   // Stall edges requested while in decode
} row_t;

localparam int n_rows = 21;

localparam row_t rows [n_rows] = '{
  '{3'd1, 32'h0000_0100, op_alu,    8'h11, 8'h21, 8'h31, 8'h41, 8'h51, 4'd0, 4'd0},
  '{3'd1, 32'h0000_0104, op_load,   8'h12, 8'h22, 8'h32, 8'h42, 8'h52, 4'd0, 4'd0},
  '{3'd1, 32'h0000_0108, op_store,  8'h13, 8'h23, 8'h33, 8'h43, 8'h53, 4'd0, 4'd0},
  '{3'd1, 32'h0000_010c, op_branch, 8'h14, 8'h24, 8'h34, 8'h44, 8'h54, 4'd0, 4'd0},
  '{3'd2, 32'h0000_0200, op_jump,   8'h61, 8'h71, 8'h81, 8'h91, 8'ha1, 4'd2, 4'd0},
  '{3'd2, 32'h0000_0204, op_alu,    8'h62, 8'h72, 8'h82, 8'h92, 8'ha2, 4'd0, 4'd3},
  '{3'd2, 32'h0000_0208, op_load,   8'h63, 8'h73, 8'h83, 8'h93, 8'ha3, 4'd4, 4'd5},
  '{3'd2, 32'h0000_020c, op_nop,    8'h64, 8'h74, 8'h84, 8'h94, 8'ha4, 4'd1, 4'd1},
  '{3'd3, 32'h0000_0300, op_store,  8'hb1, 8'hc1, 8'hd1, 8'he1, 8'hf1, 4'd0, 4'd1},
  '{3'd3, 32'h0000_0304, op_alu,    8'hb2, 8'hc2, 8'hd2, 8'he2, 8'hf2, 4'd0, 4'd0},
  '{3'd3, 32'h0000_0308, op_branch, 8'hb3, 8'hc3, 8'hd3, 8'he3, 8'hf3, 4'd2, 4'd0},
  '{3'd3, 32'h0000_030c, op_load,   8'hb4, 8'hc4, 8'hd4, 8'he4, 8'hf4, 4'd0, 4'd0},
  '{3'd3, 32'h0000_0310, op_jump,   8'hb5, 8'hc5, 8'hd5, 8'he5, 8'hf5, 4'd0, 4'd0},
  '{3'd3, 32'h0000_0314, op_alu,    8'hb6, 8'hc6, 8'hd6, 8'he6, 8'hf6, 4'd1, 4'd0},
  '{3'd4, 32'h0000_0400, op_load,   8'h01, 8'h02, 8'h03, 8'h04, 8'h05, 4'd0, 4'd0},
  '{3'd4, 32'h0000_0404, op_alu,    8'h06, 8'h07, 8'h08, 8'h09, 8'h0a, 4'd0, 4'd0},
  '{3'd4, 32'h0000_0408, op_store,  8'h0b, 8'h0c, 8'h0d, 8'h0e, 8'h0f, 4'd0, 4'd0},
  '{3'd4, 32'h0000_040c, op_alu,    8'h1a, 8'h1b, 8'h1c, 8'h1d, 8'h1e, 4'd0, 4'd0},
  '{3'd4, 32'h0000_0410, op_branch, 8'h2a, 8'h2b, 8'h2c, 8'h2d, 8'h2e, 4'd0, 4'd0},
  '{3'd4, 32'h0000_0414, op_jump,   8'h3a, 8'h3b, 8'h3c, 8'h3d, 8'h3e, 4'd0, 4'd0},
  '{3'd4, 32'h0000_0418, op_nop,    8'h4a, 8'h4b, 8'h4c, 8'h4d, 8'h4e, 4'd0, 4'd0}
};

`endif

/* tb/tb_trace_top.sv */
`timescale 1ns/1ps

module tb_trace_top;

  import trace_pkg::*;

  `include "tb_trace_table.svh"

  localparam int q_depth     = queue_depth_default;
  localparam int stall_max   = (1 << stall_cnt_w) - 1;
  localparam int cycle_limit = 40 * n_rows + 200;   // Timeout bound

  logic clk;
  logic rst_n;
  logic fetch_valid;
  logic [31:0] fetch_pc;
  logic stall;
  op_t op;
  logic [note_w-1:0] fetch_note;
  logic [note_w-1:0] decode_note;
  logic [note_w-1:0] exec_note;
  logic [note_w-1:0] mem_note;
  logic [note_w-1:0] wb_note;
  logic out_req;
  logic [31:0] out_pc;
  op_t out_op;
  logic [note_w-1:0] out_fetch_note;
  logic [note_w-1:0] out_decode_note;
  logic [note_w-1:0] out_exec_note;
  logic [note_w-1:0] out_mem_note;
  logic [note_w-1:0] out_wb_note;
  logic [stall_cnt_w-1:0] out_stall_cycles;
  logic out_ack;
  logic [7:0] drop_count;
  trace_rec_t out_view;      // Logger side fields as one record

  //////////////////////////////////////////////////
  // Model state
  //////////////////////////////////////////////////

  int         pipe [5];           // Row in each stage or -1 when empty
  int         f_left [n_rows];    // Fetch stall edges still to apply
  int         d_left [n_rows];
  int         seen [n_rows];      // Stall edges counted so far
  int         next_row = 0;
  bit         push_pending = 0;   // Queue push due on the next edge
  trace_rec_t pend_rec;
  int         model_count = 0;    // Queue occupancy
  int         exp_drops = 0;
  bit         pop_due = 0;        // Set by the logger when ack drops
  bit         hold_ack = 0;
  bit         ack_random = 0;
  bit         logger_busy = 0;
  int         cycles = 0;
  trace_rec_t exp_q [$];          // Records the logger must receive

  trace_top #(.queue_depth(q_depth)) uut (.*);

  always #2 clk = ~clk;   // 4 ns period

  always_comb begin
    out_view.pc           = out_pc;
    out_view.op           = out_op;
    out_view.fetch_note   = out_fetch_note;
    out_view.decode_note  = out_decode_note;
    out_view.exec_note    = out_exec_note;
    out_view.mem_note     = out_mem_note;
    out_view.wb_note      = out_wb_note;
    out_view.stall_cycles = out_stall_cycles;
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  task automatic end_with_failure();
    $display("TB FAILED");
    $fatal(1, "Stopping on first error");
  endtask

  task automatic check_rec(input trace_rec_t got, input trace_rec_t want, input string what);
    if (got !== want) begin
      $display("Fail %0t ns %s record mismatch", $time, what);
      $display("  got  pc %h op %0d notes %h %h %h %h %h stalls %0d", got.pc, got.op,
               got.fetch_note, got.decode_note, got.exec_note, got.mem_note, got.wb_note,
               got.stall_cycles);
      $display("  want pc %h op %0d notes %h %h %h %h %h stalls %0d", want.pc, want.op,
               want.fetch_note, want.decode_note, want.exec_note, want.mem_note,
               want.wb_note, want.stall_cycles);
      end_with_failure();
    end
  endtask

  task automatic check_count(input logic [7:0] got, input logic [7:0] want, input string what);
    if (got !== want) begin
      $display("Fail %0t ns %s is %0d, expected %0d", $time, what, got, want);
      end_with_failure();
    end
  endtask

  task automatic check_flag(input logic got, input logic want, input string what);
    if (got !== want) begin
      $display("Fail %0t ns %s is %b, expected %b", $time, what, got, want);
      end_with_failure();
    end
  endtask

  //////////////////////////////////////////////////
  // CPU model
  //////////////////////////////////////////////////

  function automatic bit pipe_busy();
    for (int i = 0; i < 5; i++) begin
      if (pipe[i] >= 0) return 1'b1;
    end
    return 1'b0;
  endfunction

  // Table fields plus the stall edges counted in fetch and decode
  function automatic trace_rec_t expect_rec(input int idx);
    trace_rec_t r;
    r.pc           = rows[idx].pc;
    r.op           = rows[idx].op;
    r.fetch_note   = rows[idx].f_note;
    r.decode_note  = rows[idx].d_note;
    r.exec_note    = rows[idx].e_note;
    r.mem_note     = rows[idx].m_note;
    r.wb_note      = rows[idx].w_note;
    r.stall_cycles = stall_cnt_w'((seen[idx] > stall_max) ? stall_max : seen[idx]);
    return r;
  endfunction

  // Bookkeeping for one rising edge
  task automatic step_model(input bit stl, input bit fv);
    if (push_pending) begin             // Full is judged before this edge's pop
      if (model_count == q_depth) begin
        if (exp_drops < 255) exp_drops++;
      end else begin
        exp_q.push_back(pend_rec);
        model_count++;
      end
    end
    if (pop_due) begin
      model_count--;
      pop_due = 1'b0;
    end
    push_pending = (pipe[4] >= 0);      // Leaving write-back now
    if (push_pending) pend_rec = expect_rec(pipe[4]);
    if (stl) begin
      if (pipe[0] >= 0) begin
        seen[pipe[0]]++;
        if (f_left[pipe[0]] > 0) f_left[pipe[0]]--;
      end
      if (pipe[1] >= 0) begin
        seen[pipe[1]]++;
        if (d_left[pipe[1]] > 0) d_left[pipe[1]]--;
      end
      pipe[4] = pipe[3];
      pipe[3] = pipe[2];
      pipe[2] = -1;                     // Bubble into execute
    end else begin
      for (int i = 4; i > 0; i--) pipe[i] = pipe[i-1];
      pipe[0] = fv ? next_row : -1;
      if (fv) next_row++;
    end
  endtask

  // Drive CPU inputs for one cycle 1 ns after the edge
  task automatic cpu_cycle(input bit offer);
    bit stl;
    bit fv;
    stl = (pipe[0] >= 0 && f_left[pipe[0]] > 0) || (pipe[1] >= 0 && d_left[pipe[1]] > 0);
    fv  = offer && !stl && (next_row < n_rows);
    stall       = stl;
    fetch_valid = fv;
    fetch_pc    = fv ? rows[next_row].pc : '0;
    fetch_note  = (pipe[0] >= 0) ? rows[pipe[0]].f_note : '0;
    decode_note = (pipe[1] >= 0) ? rows[pipe[1]].d_note : '0;
    op          = (pipe[1] >= 0) ? rows[pipe[1]].op : op_nop;
    exec_note   = (pipe[2] >= 0) ? rows[pipe[2]].e_note : '0;
    mem_note    = (pipe[3] >= 0) ? rows[pipe[3]].m_note : '0;
    wb_note     = (pipe[4] >= 0) ? rows[pipe[4]].w_note : '0;
    @(posedge clk);
    step_model(stl, fv);
    #1;
    check_count(drop_count, 8'(exp_drops), "drop_count");
  endtask

  task automatic drain();
    while (pipe_busy() || push_pending || model_count != 0 || exp_q.size() != 0 ||
           logger_busy || out_req) begin
      cpu_cycle(1'b0);
    end
  endtask

  task automatic run_phase(input int p);
    int first;
    int drops_start;
    first       = next_row;
    drops_start = exp_drops;
    ack_random  = (p == 3);
    hold_ack    = (p == 4);            // Logger stalls for the whole burst
    while (next_row < n_rows && int'(rows[next_row].phase) == p) cpu_cycle(1'b1);
    if (p == 4) begin
      while (pipe_busy() || push_pending) cpu_cycle(1'b0);
      // Queue keeps depth records and drops the rest
      check_count(drop_count, 8'(drops_start + (next_row - first) - q_depth), "burst drops");
      hold_ack = 1'b0;
    end
    drain();
  endtask

  //////////////////////////////////////////////////
  // Logger responder
  //////////////////////////////////////////////////

  function automatic int pick_delay();
    return ack_random ? int'($urandom % 6) : 0;
  endfunction

  initial begin : logger
    trace_rec_t want;
    int         wait_n;
    void'($urandom(15932));
    forever begin
      @(posedge clk);
      #1;
      if (rst_n && out_req) begin
        logger_busy = 1'b1;
        if (exp_q.size() == 0) begin
          $display("Logger got a request while no record was expected");
          end_with_failure();
        end
        want = exp_q.pop_front();
        check_rec(out_view, want, "req rise");
        wait_n = pick_delay();
        while (hold_ack || wait_n > 0) begin   // Fields checked every cycle
          @(posedge clk);
          #1;
          check_flag(out_req, 1'b1, "out_req before ack");
          check_rec(out_view, want, "req held");
          if (!hold_ack && wait_n > 0) wait_n--;
        end
        out_ack = 1'b1;
        do begin
          @(posedge clk);
          #1;
          check_rec(out_view, want, "ack high");
        end while (out_req);
        wait_n = pick_delay();
        while (wait_n > 0) begin
          @(posedge clk);
          #1;
          check_flag(out_req, 1'b0, "out_req after ack");
          check_rec(out_view, want, "req released");
          wait_n--;
        end
        out_ack     = 1'b0;
        pop_due     = 1'b1;                  // Sender pops on the next edge
        logger_busy = 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Run stopped by timeout after %0d cycles", cycles);
      end_with_failure();
    end
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    fetch_valid = 1'b0;
    fetch_pc = '0;
    stall = 1'b0;
    op = op_nop;
    fetch_note = '0;
    decode_note = '0;
    exec_note = '0;
    mem_note = '0;
    wb_note = '0;
    out_ack = 1'b0;
    for (int i = 0; i < 5; i++) pipe[i] = -1;
    for (int i = 0; i < n_rows; i++) begin
      f_left[i] = int'(rows[i].f_stall);
      d_left[i] = int'(rows[i].d_stall);
      seen[i]   = 0;
    end
    repeat (8) @(posedge clk);
    #1;
    check_flag(out_req, 1'b0, "out_req in reset");
    check_count(drop_count, 8'd0, "drop_count in reset");
    rst_n = 1'b1;
    repeat (4) begin                     // Quiet until something retires
      cpu_cycle(1'b0);
      check_flag(out_req, 1'b0, "out_req before first retire");
    end
    for (int p = 1; p <= 4; p++) run_phase(p);
    if (exp_q.size() == 0 && model_count == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      $display("Records were left undelivered at the end of the run");
      end_with_failure();
    end
  end

endmodule

/* vlog.f */
+incdir+tb
design/trace_pkg.sv
design/retire_if.sv
design/stage_tracker.sv
design/retire_queue.sv
design/retire_sender.sv
design/trace_top.sv
tb/tb_trace_top.sv
